//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       ?= tb_mips
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := === PASS ===

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and look for the pass line in $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/mips_checker.sv
`include "mips_cfg.svh"
`default_nettype none

module mips_checker (
    input  wire                     i_clk,
    input  wire                     i_rst_n,
    input  wire                     i_program_memory_write,
    input  wire [`MIPS_XLEN-1:0]    i_instruction_write,
    input  wire [`MIPS_IMEM_AW-1:0] i_address_write,
    input  wire                     i_stop_signal,
    input  wire [`MIPS_XLEN-1:0]    i_dbg_reg_data,
    output int                      o_error_count
);

    timeunit 1ns;
    timeprecision 1ps;

    import mips_isa_pkg::*;

    logic [`MIPS_XLEN-1:0] prog [2**`MIPS_IMEM_AW];
    logic [`MIPS_XLEN-1:0] model [2**`MIPS_REG_AW];
    logic                  stop_seen;
    int                    value_errors = 0;
    int                    stop_errors = 0;

    assign o_error_count = value_errors + stop_errors;

    // copy of the program as it goes into the core
    always @(posedge i_clk) begin
        if (i_program_memory_write) begin
            prog[i_address_write] <= i_instruction_write;
        end
    end

    function automatic void write_model_reg(input logic [4:0] r, input logic [31:0] v);
        if (r != 5'd0) begin
            model[r] = v;
        end
    endfunction

    // in-order execution up to the halt word
    task automatic run_model();
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sx;
        logic [31:0] zx;
        for (int r = 0; r < 2**`MIPS_REG_AW; r++) begin
            model[r] = '0;
        end
        for (int pc = 0; pc < 2**`MIPS_IMEM_AW; pc++) begin
            w = prog[pc];
            if (w == `MIPS_HALT_WORD) begin
                break;
            end
            a  = model[w[25:21]];
            b  = model[w[20:16]];
            sx = {{16{w[15]}}, w[15:0]};
            zx = {16'h0000, w[15:0]};
            case (w[31:26])
                OP_RTYPE: begin
                    case (w[5:0])
                        F_ADD:   write_model_reg(w[15:11], a + b);
                        F_SUB:   write_model_reg(w[15:11], a - b);
                        F_AND:   write_model_reg(w[15:11], a & b);
                        F_OR:    write_model_reg(w[15:11], a | b);
                        F_SLT:   write_model_reg(w[15:11], {31'd0, $signed(a) < $signed(b)});
                        default: ;
                    endcase
                end
                OP_ADDI: write_model_reg(w[20:16], a + sx);
                OP_ORI:  write_model_reg(w[20:16], a | zx);
                OP_LUI:  write_model_reg(w[20:16], {w[15:0], 16'h0000});
                default: ;
            endcase
        end
    endtask

    task automatic check_reg(input string name, input logic [4:0] r);
        if (i_dbg_reg_data !== model[r]) begin
            value_errors++;
            $display("ERROR %s: r%0d expected %08h actual %08h",
                     name, r, model[r], i_dbg_reg_data);
        end
    endtask

    // stop must stay up until the next reset
    always @(posedge i_clk) begin
        if (!i_rst_n) begin
            stop_seen <= 1'b0;
        end else begin
            if (i_stop_signal) begin
                stop_seen <= 1'b1;
            end
            if (stop_seen && !i_stop_signal) begin
                stop_errors <= stop_errors + 1;
                $display("stop signal fell after the core had halted");
            end
        end
    end

endmodule

`default_nettype wire

//--- dv/tb_mips.sv
`include "mips_cfg.svh"
`default_nettype none

module tb_mips;

    timeunit 1ns;
    timeprecision 1ps;

    import mips_isa_pkg::*;

    logic                     clk = 1'b0;
    logic                     rst_n;
    logic                     step;
    logic                     prog_we;
    logic [`MIPS_XLEN-1:0]    prog_word;
    logic [`MIPS_IMEM_AW-1:0] prog_addr;
    logic [`MIPS_REG_AW-1:0]  dbg_addr;
    wire  [`MIPS_XLEN-1:0]    dbg_data;
    wire                      stop;
    int                       chk_errors;
    int                       tb_errors = 0;
    int                       cycles = 0;
    int                       cycle_limit = 0;
    int                       seed;

    // program table: word, test name, checked register, check enable
    logic [`MIPS_XLEN-1:0]    word_q [$];
    string                    name_q [$];
    logic [`MIPS_REG_AW-1:0]  reg_q [$];
    bit                       chk_q [$];

    always #5 clk = ~clk;

    mips_core i_dut (
        .i_clk                  (clk),
        .i_rst_n                (rst_n),
        .i_step                 (step),
        .i_program_memory_write (prog_we),
        .i_instruction_write    (prog_word),
        .i_address_write        (prog_addr),
        .i_dbg_reg_addr         (dbg_addr),
        .o_dbg_reg_data         (dbg_data),
        .o_stop_signal          (stop)
    );

    mips_checker u_checker (
        .i_clk                  (clk),
        .i_rst_n                (rst_n),
        .i_program_memory_write (prog_we),
        .i_instruction_write    (prog_word),
        .i_address_write        (prog_addr),
        .i_stop_signal          (stop),
        .i_dbg_reg_data         (dbg_data),
        .o_error_count          (chk_errors)
    );

    task automatic report_counts();
        $display("errors: %0d checker, %0d testbench", chk_errors, tb_errors);
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            tb_errors++;
            $display("timeout: core did not stop within %0d cycles", cycle_limit);
            report_counts();
            $display("=== FAIL ===");
            $finish;
        end
    end

    function automatic logic [31:0] rtype(input funct_e f, input logic [4:0] rd,
                                          input logic [4:0] rs, input logic [4:0] rt);
        return {OP_RTYPE, rs, rt, rd, 5'd0, f};
    endfunction

    function automatic logic [31:0] itype(input op_e op, input logic [4:0] rt,
                                          input logic [4:0] rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic add_entry(input logic [31:0] w, input string name,
                             input logic [4:0] r, input bit chk);
        word_q.push_back(w);
        name_q.push_back(name);
        reg_q.push_back(r);
        chk_q.push_back(chk);
    endtask

    task automatic build_table();
        add_entry(itype(OP_ORI, 1, 0, 16'h0005), "ori_small", 1, 1);
        add_entry(itype(OP_ADDI, 2, 0, 16'hfffd), "addi_neg", 2, 1);
        add_entry(rtype(F_ADD, 3, 1, 2), "add_fwd", 3, 1);
        add_entry(rtype(F_SUB, 4, 2, 1), "sub_neg", 4, 1);
        add_entry(rtype(F_AND, 5, 2, 4), "and_neg", 5, 0);
        add_entry(rtype(F_OR, 6, 1, 4), "or_neg", 6, 1);
        add_entry(rtype(F_SLT, 7, 4, 1), "slt_neg_true", 7, 1);
        add_entry(rtype(F_SLT, 8, 1, 2), "slt_neg_false", 8, 1);
        add_entry(itype(OP_LUI, 9, 0, 16'h8001), "lui_high", 9, 0);
        add_entry(itype(OP_ORI, 9, 9, 16'hf00f), "ori_zext_high", 9, 1);
        add_entry(itype(OP_ADDI, 10, 9, 16'h8000), "addi_sext_high", 10, 1);
        add_entry(itype(OP_ORI, 11, 0, 16'h8000), "ori_zext", 11, 1);
        add_entry(itype(OP_ADDI, 12, 11, 16'h0001), "chain_start", 12, 0);
        add_entry(rtype(F_ADD, 12, 12, 12), "chain_double", 12, 0);
        add_entry(rtype(F_ADD, 12, 12, 1), "chain_back_to_back", 12, 1);
        add_entry(itype(OP_ADDI, 13, 0, 16'h0007), "chain_seed", 13, 0);
        add_entry(itype(OP_ADDI, 14, 0, 16'h0001), "addi_small", 14, 1);
        add_entry(rtype(F_SUB, 13, 13, 14), "chain_one_apart", 13, 1);
        add_entry(32'h0000_0000, "nop", 0, 0);
        add_entry(itype(OP_ADDI, 0, 1, 16'h0009), "r0_write", 0, 1);
        add_entry(rtype(F_ADD, 15, 0, 1), "r0_read", 15, 1);
        add_entry(itype(OP_ADDI, 16, 0, 16'h1234), "pre_halt", 16, 0);
        add_entry(`MIPS_HALT_WORD, "halt", 0, 0);
        // everything below the halt must never write
        add_entry(itype(OP_ADDI, 16, 0, 16'h0001), "halt_keeps_r16", 16, 1);
        add_entry(rtype(F_ADD, 3, 1, 1), "halt_keeps_r3", 3, 1);
        add_entry(rtype(F_OR, 5, 0, 0), "halt_keeps_r5", 5, 1);
    endtask

    task automatic apply_reset();
        @(negedge clk);
        rst_n = 1'b0;
        step  = 1'b0;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
    endtask

    task automatic load_program();
        for (int i = 0; i < word_q.size(); i++) begin
            @(negedge clk);
            prog_we   = 1'b1;
            prog_addr = i[`MIPS_IMEM_AW-1:0];
            prog_word = word_q[i];
        end
        @(negedge clk);
        prog_we = 1'b0;
    endtask

    task automatic run_to_halt(input bit random_step);
        logic [31:0] rnd;
        @(negedge clk);
        if (stop) begin
            tb_errors++;
            $display("stop signal was high before the run started");
        end
        while (!stop) begin
            if (random_step) begin
                rnd  = $random(seed);
                step = rnd[0];
            end else begin
                step = 1'b1;
            end
            @(negedge clk);
        end
        // halted pipe keeps stepping, nothing may move
        step = 1'b1;
        repeat (8) @(negedge clk);
        step = 1'b0;
    endtask

    // stale value in every register before the next run
    task automatic scrub_registers();
        for (int i = 0; i < 2**`MIPS_REG_AW - 1; i++) begin
            @(negedge clk);
            prog_we   = 1'b1;
            prog_addr = i[`MIPS_IMEM_AW-1:0];
            prog_word = itype(OP_ORI, 5'(i + 1), 5'd0, 16'hdead);
        end
        @(negedge clk);
        prog_addr = prog_addr + 1'b1;
        prog_word = `MIPS_HALT_WORD;
        @(negedge clk);
        prog_we = 1'b0;
        apply_reset();
        run_to_halt(1'b0);
    endtask

    // called on a falling edge, samples on the rising one
    task automatic check_registers();
        for (int i = 0; i < word_q.size(); i++) begin
            if (chk_q[i]) begin
                dbg_addr = reg_q[i];
                @(posedge clk);
                u_checker.check_reg(name_q[i], reg_q[i]);
                @(negedge clk);
            end
        end
    endtask

    initial begin
        rst_n     = 1'b0;
        step      = 1'b0;
        prog_we   = 1'b0;
        prog_word = '0;
        prog_addr = '0;
        dbg_addr  = '0;
        seed      = 32'heef4_e99d;
        build_table();
        cycle_limit = 8 * word_q.size() + 200;
        apply_reset();
        load_program();
        u_checker.run_model();
        run_to_halt(1'b0);
        check_registers();
        scrub_registers();
        // same program again, step now ragged
        apply_reset();
        load_program();
        run_to_halt(1'b1);
        check_registers();
        report_counts();
        if (chk_errors + tb_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- logic/mips_cfg.svh
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

`default_nettype none

// data and instruction width
`define MIPS_XLEN 32
// register address width
`define MIPS_REG_AW 5
// program memory holds 2**MIPS_IMEM_AW words
`define MIPS_IMEM_AW 8
// all-ones word stops the core
`define MIPS_HALT_WORD 32'hffff_ffff

`default_nettype wire

`endif

//--- logic/mips_core.sv
`include "mips_cfg.svh"
`default_nettype none

module mips_core (
    input  wire                       i_clk,
    input  wire                       i_rst_n,
    input  wire                       i_step,
    input  wire                       i_program_memory_write,
    input  wire [`MIPS_XLEN-1:0]      i_instruction_write,
    input  wire [`MIPS_IMEM_AW-1:0]   i_address_write,
    input  wire [`MIPS_REG_AW-1:0]    i_dbg_reg_addr,
    output logic [`MIPS_XLEN-1:0]     o_dbg_reg_data,
    output logic                      o_stop_signal
);

    import mips_pipe_pkg::*;

    if_id_t if_id;
    id_ex_t id_ex;
    logic   pc_write;

    mips_wb_if wb ();

    // halt in writeback freezes the pc
    assign pc_write      = !wb.halt;
    assign o_stop_signal = wb.halt;

    mips_fetch u_fetch (
        .i_clk                  (i_clk),
        .i_rst_n                (i_rst_n),
        .i_step                 (i_step),
        .i_program_memory_write (i_program_memory_write),
        .i_instruction_write    (i_instruction_write),
        .i_address_write        (i_address_write),
        .i_pc_write             (pc_write),
        .o_if_id                (if_id)
    );

    mips_decode u_decode (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_step         (i_step),
        .i_if_id        (if_id),
        .wb             (wb.regfile),
        .i_dbg_reg_addr (i_dbg_reg_addr),
        .o_id_ex        (id_ex),
        .o_dbg_reg_data (o_dbg_reg_data)
    );

    mips_execute u_execute (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_step  (i_step),
        .i_id_ex (id_ex),
        .wb      (wb.src)
    );

endmodule

`default_nettype wire

//--- logic/mips_decode.sv
`include "mips_cfg.svh"
`default_nettype none

module mips_decode (
    input  wire                       i_clk,
    input  wire                       i_rst_n,
    input  wire                       i_step,
    input  mips_pipe_pkg::if_id_t     i_if_id,
    mips_wb_if.regfile                wb,
    input  wire [`MIPS_REG_AW-1:0]    i_dbg_reg_addr,
    output mips_pipe_pkg::id_ex_t     o_id_ex,
    output logic [`MIPS_XLEN-1:0]     o_dbg_reg_data
);

    import mips_isa_pkg::*;
    import mips_pipe_pkg::*;

    logic [`MIPS_XLEN-1:0]   regs [2**`MIPS_REG_AW];
    logic [`MIPS_XLEN-1:0]   instr;
    op_e                     opcode;
    funct_e                  funct;
    logic [`MIPS_REG_AW-1:0] rs;
    logic [`MIPS_REG_AW-1:0] rt;
    logic [`MIPS_REG_AW-1:0] rd;
    logic [15:0]             imm16;
    id_ex_t                  id_ex_d;

    // r0 reads zero, writes this cycle pass straight through
    function automatic logic [`MIPS_XLEN-1:0] rf_read(input logic [`MIPS_REG_AW-1:0] a);
        if (a == '0) begin
            return '0;
        end else if (wb.we && wb.addr == a) begin
            return wb.data;
        end
        return regs[a];
    endfunction

    always_ff @(posedge i_clk) begin
        if (i_step && wb.we && wb.addr != '0) begin
            regs[wb.addr] <= wb.data;
        end
    end

    always_comb begin
        o_dbg_reg_data = rf_read(i_dbg_reg_addr);
    end

    assign instr  = i_if_id.instruction;
    assign opcode = op_e'(instr[31:26]);
    assign funct  = funct_e'(instr[5:0]);
    assign rs     = instr[25:21];
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];
    assign imm16  = instr[15:0];

    always_comb begin
        id_ex_d          = '0;
        id_ex_d.valid    = i_if_id.valid;
        id_ex_d.rs_addr  = rs;
        id_ex_d.rt_addr  = rt;
        id_ex_d.dst_addr = rd;
        id_ex_d.rs_val   = rf_read(rs);
        id_ex_d.rt_val   = rf_read(rt);
        id_ex_d.imm      = {{16{imm16[15]}}, imm16};
        id_ex_d.alu_op   = ALU_ADD;
        case (opcode)
            OP_RTYPE: begin
                id_ex_d.reg_write = 1'b1;
                case (funct)
                    F_ADD:   id_ex_d.alu_op = ALU_ADD;
                    F_SUB:   id_ex_d.alu_op = ALU_SUB;
                    F_AND:   id_ex_d.alu_op = ALU_AND;
                    F_OR:    id_ex_d.alu_op = ALU_OR;
                    F_SLT:   id_ex_d.alu_op = ALU_SLT;
                    // nop and unknown functions
                    default: id_ex_d.reg_write = 1'b0;
                endcase
            end
            OP_ADDI: begin
                id_ex_d.reg_write = 1'b1;
                id_ex_d.alu_src   = 1'b1;
                id_ex_d.dst_addr  = rt;
            end
            OP_ORI: begin
                id_ex_d.reg_write = 1'b1;
                id_ex_d.alu_src   = 1'b1;
                id_ex_d.dst_addr  = rt;
                id_ex_d.alu_op    = ALU_OR;
                id_ex_d.imm       = {16'h0000, imm16};
            end
            OP_LUI: begin
                id_ex_d.reg_write = 1'b1;
                id_ex_d.alu_src   = 1'b1;
                id_ex_d.dst_addr  = rt;
                id_ex_d.alu_op    = ALU_LUI;
                id_ex_d.imm       = {imm16, 16'h0000};
            end
            OP_HALT: id_ex_d.halt = (instr == `MIPS_HALT_WORD);
            default: ;
        endcase
    end

    // ID/EX latch
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_id_ex.valid     <= 1'b0;
            o_id_ex.halt      <= 1'b0;
            o_id_ex.reg_write <= 1'b0;
        end else if (i_step) begin
            o_id_ex <= id_ex_d;
        end
    end

endmodule

`default_nettype wire

//--- logic/mips_execute.sv
`include "mips_cfg.svh"
`default_nettype none

module mips_execute (
    input  wire                       i_clk,
    input  wire                       i_rst_n,
    input  wire                       i_step,
    input  mips_pipe_pkg::id_ex_t     i_id_ex,
    mips_wb_if.src                    wb
);

    import mips_isa_pkg::*;

    logic [`MIPS_XLEN-1:0] op_a;
    logic [`MIPS_XLEN-1:0] rt_fwd;
    logic [`MIPS_XLEN-1:0] op_b;
    logic [`MIPS_XLEN-1:0] alu_res;
    logic                  slt;

    // result latch wins over the value read in decode
    function automatic logic [`MIPS_XLEN-1:0] fwd(
        input logic [`MIPS_REG_AW-1:0] a,
        input logic [`MIPS_XLEN-1:0]   val
    );
        if (wb.we && wb.addr != '0 && wb.addr == a) begin
            return wb.data;
        end
        return val;
    endfunction

    always_comb begin
        op_a   = fwd(i_id_ex.rs_addr, i_id_ex.rs_val);
        rt_fwd = fwd(i_id_ex.rt_addr, i_id_ex.rt_val);
    end

    assign op_b = i_id_ex.alu_src ? i_id_ex.imm : rt_fwd;

    // signed compare
    assign slt = $signed(op_a) < $signed(op_b);

    always_comb begin
        case (i_id_ex.alu_op)
            ALU_ADD: alu_res = op_a + op_b;
            ALU_SUB: alu_res = op_a - op_b;
            ALU_AND: alu_res = op_a & op_b;
            ALU_OR:  alu_res = op_a | op_b;
            ALU_SLT: alu_res = {{(`MIPS_XLEN-1){1'b0}}, slt};
            // immediate already shifted in decode
            ALU_LUI: alu_res = op_b;
            default: alu_res = op_a + op_b;
        endcase
    end

    // result latch, frozen for good once it carries the halt word
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            wb.we   <= 1'b0;
            wb.halt <= 1'b0;
        end else if (i_step && !wb.halt) begin
            wb.we   <= i_id_ex.valid && i_id_ex.reg_write;
            wb.halt <= i_id_ex.valid && i_id_ex.halt;
            wb.addr <= i_id_ex.dst_addr;
            wb.data <= alu_res;
        end
    end

endmodule

`default_nettype wire

//--- logic/mips_fetch.sv
`include "mips_cfg.svh"
`default_nettype none

module mips_fetch (
    input  wire                       i_clk,
    input  wire                       i_rst_n,
    input  wire                       i_step,
    input  wire                       i_program_memory_write,
    input  wire [`MIPS_XLEN-1:0]      i_instruction_write,
    input  wire [`MIPS_IMEM_AW-1:0]   i_address_write,
    input  wire                       i_pc_write,
    output mips_pipe_pkg::if_id_t     o_if_id
);

    logic [`MIPS_XLEN-1:0]    imem [2**`MIPS_IMEM_AW];
    logic [`MIPS_XLEN-1:0]    pc;
    logic [`MIPS_IMEM_AW-1:0] word_addr;

    assign word_addr = pc[`MIPS_IMEM_AW+1:2];

    // loader port, runs regardless of step
    always_ff @(posedge i_clk) begin
        if (i_program_memory_write) begin
            imem[i_address_write] <= i_instruction_write;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            pc <= '0;
        end else if (i_step && i_pc_write) begin
            pc <= pc + `MIPS_XLEN'd4;
        end
    end

    // IF/ID latch
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_if_id.valid <= 1'b0;
        end else if (i_step) begin
            o_if_id.pc          <= pc;
            o_if_id.instruction <= imem[word_addr];
            // frozen pc only refetches, send bubbles
            o_if_id.valid       <= i_pc_write;
        end
    end

endmodule

`default_nettype wire

//--- logic/mips_isa_pkg.sv
`default_nettype none

package mips_isa_pkg;

    // primary opcode, instr[31:26]
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_ADDI  = 6'h08,
        OP_ORI   = 6'h0d,
        OP_LUI   = 6'h0f,
        OP_HALT  = 6'h3f
    } op_e;

    // r-type function field, instr[5:0]
    typedef enum logic [5:0] {
        F_ADD = 6'h20,
        F_SUB = 6'h22,
        F_AND = 6'h24,
        F_OR  = 6'h25,
        F_SLT = 6'h2a
    } funct_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_LUI
    } alu_op_e;

endpackage

`default_nettype wire

//--- logic/mips_pipe_pkg.sv
`include "mips_cfg.svh"
`default_nettype none

package mips_pipe_pkg;

    typedef struct packed {
        logic [`MIPS_XLEN-1:0] pc;
        logic [`MIPS_XLEN-1:0] instruction;
        logic                  valid;
    } if_id_t;

    // operands and control for the execute stage
    typedef struct packed {
        logic                    valid;
        logic                    halt;
        logic                    reg_write;
        logic [`MIPS_REG_AW-1:0] rs_addr;
        logic [`MIPS_REG_AW-1:0] rt_addr;
        logic [`MIPS_REG_AW-1:0] dst_addr;
        logic [`MIPS_XLEN-1:0]   rs_val;
        logic [`MIPS_XLEN-1:0]   rt_val;
        logic [`MIPS_XLEN-1:0]   imm;
        logic                    alu_src;
        mips_isa_pkg::alu_op_e   alu_op;
    } id_ex_t;

endpackage

`default_nettype wire

//--- logic/mips_wb_if.sv
`include "mips_cfg.svh"
`default_nettype none

// result latch to register file
interface mips_wb_if;

    logic                    we;
    logic [`MIPS_REG_AW-1:0] addr;
    logic [`MIPS_XLEN-1:0]   data;
    // halt word has reached writeback
    logic                    halt;

    modport src (output we, output addr, output data, output halt);

    modport regfile (input we, input addr, input data);

endinterface

`default_nettype wire

//--- vlog.f
+incdir+logic
logic/mips_isa_pkg.sv
logic/mips_pipe_pkg.sv
logic/mips_wb_if.sv
logic/mips_fetch.sv
logic/mips_decode.sv
logic/mips_execute.sv
logic/mips_core.sv
dv/mips_checker.sv
dv/tb_mips.sv
